/* source/pipe_defines.svh */
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// Register address width of the core
`define REG_ADDR_W 4

// Operand and result width of the multi-cycle unit
`define MCYCLE_W 32

// Iteration counter width, log2 of the operand width
`define MCYCLE_CNT_W 5

`endif

/* source/pipePkg.sv */
package pipePkg;

    ////////////////////////////////////////////////////////////
    // Multi-cycle unit types
    ////////////////////////////////////////////////////////////

    // Sequencer states
    typedef enum logic [1:0] {
        Idle,
        Compute,
        Done
    } mcycleStateT;

    // Operation select, latched at start
    typedef enum logic {
        Mul,
        Divu
    } mcycleOpT;

endpackage

/* source/HazardUnit.sv */
`timescale 1ns/1ns

`include "pipe_defines.svh"

module HazardUnit (
    input  logic [`REG_ADDR_W-1:0] ra1D,
    input  logic [`REG_ADDR_W-1:0] ra2D,
    input  logic [`REG_ADDR_W-1:0] wa3D,
    input  logic [`REG_ADDR_W-1:0] ra1E,
    input  logic [`REG_ADDR_W-1:0] ra2E,
    input  logic [`REG_ADDR_W-1:0] wa3E,
    input  logic [`REG_ADDR_W-1:0] ra2M,
    input  logic [`REG_ADDR_W-1:0] wa3M,
    input  logic [`REG_ADDR_W-1:0] wa3W,
    input  logic                   regWriteE,
    input  logic                   regWriteM,
    input  logic                   regWriteW,
    input  logic                   memWriteM,
    input  logic                   memtoRegE,
    input  logic                   memtoRegW,
    input  logic                   pcSrcE,
    input  logic [`REG_ADDR_W-1:0] mcycleWa3,
    input  logic                   mcycleDone,
    input  logic                   mcycleBusy,
    input  logic                   mStart,
    input  logic                   mS,
    input  logic                   cacheHit,
    input  logic                   rw,
    input  logic                   memReadReady,
    output logic [1:0]             forwardAE,
    output logic [1:0]             forwardBE,
    output logic                   forwardM,
    output logic                   stallF,
    output logic                   stallD,
    output logic                   stallE,
    output logic                   stallM,
    output logic                   flushD,
    output logic                   flushE,
    output logic                   mcycleHazard
);

    ////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////

    logic match1EM;
    logic match2EM;
    logic match1EW;
    logic match2EW;

    assign match1EM = (ra1E == wa3M) && regWriteM;
    assign match2EM = (ra2E == wa3M) && regWriteM;
    assign match1EW = (ra1E == wa3W) && regWriteW;
    assign match2EW = (ra2E == wa3W) && regWriteW;

    // Memory result is younger, so it wins over Writeback
    always_comb begin
        forwardAE = 2'b00;
        if (match1EM) begin
            forwardAE = 2'b10;
        end else if (match1EW) begin
            forwardAE = 2'b01;
        end

        forwardBE = 2'b00;
        if (match2EM) begin
            forwardBE = 2'b10;
        end else if (match2EW) begin
            forwardBE = 2'b01;
        end
    end

    // Store data loaded by the instruction just ahead
    assign forwardM = (ra2M == wa3W) && memWriteM && memtoRegW && regWriteW;

    ////////////////////////////////////////////////////////////
    // Stall and flush
    ////////////////////////////////////////////////////////////

    logic loadStall;
    logic memStall;
    logic mcycleConflict;
    logic frontStall;

    assign loadStall = ((ra1D == wa3E) || (ra2D == wa3E)) && memtoRegE && regWriteE;

    // Read miss while memory still fetching the line (rw low is a read)
    assign memStall = !cacheHit && !rw && !memReadReady;

    // Decode touches the register the multi-cycle unit will write
    assign mcycleConflict = (ra1D == mcycleWa3) || (ra2D == mcycleWa3) ||
                            (wa3D == mcycleWa3) || (mStart && (wa3D == wa3E));

    assign frontStall = loadStall || mcycleDone || (mcycleConflict && mcycleBusy) || memStall;

    assign stallF = frontStall;
    assign stallD = frontStall;
    assign stallE = memStall;
    assign stallM = memStall;
    assign flushD = pcSrcE;
    assign flushE = loadStall || pcSrcE;

    assign mcycleHazard = mcycleConflict || (mcycleBusy && mS);

    // Execute is not both held and bubbled by a cache miss, except on a taken branch
    always_comb begin
        assert final (!(flushE && stallE && memStall) || pcSrcE)
            else $error("HazardUnit: flushE and stallE together during memory stall");
    end

endmodule

/* source/mcycleFsm.sv */
`timescale 1ns/1ns

`include "pipe_defines.svh"

module mcycleFsm (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   mStart,
    input  logic [`REG_ADDR_W-1:0] wa3E,
    input  pipePkg::mcycleOpT      mcycleOp,
    input  logic                   lastStep,
    output logic                   load,
    output logic                   step,
    output logic                   cntClear,
    output pipePkg::mcycleOpT      opLatched,
    output logic                   mcycleBusy,
    output logic                   mcycleDone,
    output logic [`REG_ADDR_W-1:0] mcycleWa3
);

    import pipePkg::*;

    mcycleStateT state;
    mcycleStateT stateNext;
    logic        accept;

    // Only a fresh start in Idle is taken, never during the done pulse
    assign accept = (state == Idle) && mStart && !mcycleDone;

    always_comb begin
        stateNext = state;
        case (state)
            Idle:    if (accept) stateNext = Compute;
            Compute: if (lastStep) stateNext = Done;
            Done:    stateNext = Idle;
            default: stateNext = Idle;
        endcase
    end

    assign load       = accept;
    assign cntClear   = accept;
    assign step       = (state == Compute);
    assign mcycleBusy = (state != Idle);

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            state     <= Idle;
            mcycleDone <= 1'b0;
            opLatched <= Mul;
            mcycleWa3 <= '0;
        end else begin
            state <= stateNext;
            // Pulse as the unit drops back to Idle
            mcycleDone <= (state == Done);
            if (accept) begin
                opLatched <= mcycleOp;
                mcycleWa3 <= wa3E;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    doneOnePulse: assert property (@(posedge CLK) disable iff (!rstN)
        mcycleDone |=> !mcycleDone)
        else $error("mcycleFsm: done held longer than one cycle");

    busyDoneExclusive: assert property (@(posedge CLK) disable iff (!rstN)
        !(mcycleBusy && mcycleDone))
        else $error("mcycleFsm: busy and done both high");

endmodule

/* source/mcycleCounter.sv */
`timescale 1ns/1ns

`include "pipe_defines.svh"

module mcycleCounter (
    input  logic CLK,
    input  logic rstN,
    input  logic cntClear,
    input  logic step,
    output logic lastStep
);

    logic [`MCYCLE_CNT_W-1:0] count;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            count <= '0;
        end else if (cntClear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    // Count of steps already done, so all ones marks the final iteration
    assign lastStep = step && (count == {`MCYCLE_CNT_W{1'b1}});

endmodule

/* source/mcycleDatapath.sv */
`timescale 1ns/1ns

`include "pipe_defines.svh"

module mcycleDatapath (
    input  logic                 CLK,
    input  logic                 rstN,
    input  logic                 load,
    input  logic                 step,
    input  pipePkg::mcycleOpT    opLatched,
    input  logic [`MCYCLE_W-1:0] operand1,
    input  logic [`MCYCLE_W-1:0] operand2,
    output logic [`MCYCLE_W-1:0] mcycleResult
);

    import pipePkg::*;

    // Product accumulator for multiply, remainder for divide
    logic [`MCYCLE_W-1:0] partial;
    // Operand 2, multiplicand shifting left or the fixed divisor
    logic [`MCYCLE_W-1:0] opA;
    // Operand 1, multiplier shifting right or dividend turning into quotient
    logic [`MCYCLE_W-1:0] opB;

    logic [`MCYCLE_W:0]   remShift;
    logic [`MCYCLE_W+1:0] trial;
    logic                 trialOk;

    ////////////////////////////////////////////////////////////
    // Restoring divide trial subtraction
    ////////////////////////////////////////////////////////////

    always_comb begin
        remShift = {partial, opB[`MCYCLE_W-1]};
        trial    = {1'b0, remShift} - {2'b00, opA};
        // No borrow means the divisor fits, zero divisor always fits
        trialOk  = !trial[`MCYCLE_W+1];
    end

    ////////////////////////////////////////////////////////////
    // Iteration registers
    ////////////////////////////////////////////////////////////

    // Same operand roles for both operations, opLatched only settles at the load edge
    always_ff @(posedge CLK) begin
        if (load) begin
            opA <= operand2;
        end else if (step && (opLatched == Mul)) begin
            opA <= opA << 1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            partial <= '0;
            opB     <= '0;
        end else if (load) begin
            partial <= '0;
            opB     <= operand1;
        end else if (step) begin
            if (opLatched == Mul) begin
                if (opB[0]) begin
                    partial <= partial + opA;
                end
                opB <= opB >> 1;
            end else begin
                if (trialOk) begin
                    partial <= trial[`MCYCLE_W-1:0];
                end else begin
                    partial <= remShift[`MCYCLE_W-1:0];
                end
                opB <= {opB[`MCYCLE_W-2:0], trialOk};
            end
        end
    end

    // Low product word or quotient
    assign mcycleResult = (opLatched == Mul) ? partial : opB;

endmodule

/* source/pipeCtrlTop.sv */
`timescale 1ns/1ns

`include "pipe_defines.svh"

module pipeCtrlTop (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic [`REG_ADDR_W-1:0] ra1D,
    input  logic [`REG_ADDR_W-1:0] ra2D,
    input  logic [`REG_ADDR_W-1:0] wa3D,
    input  logic [`REG_ADDR_W-1:0] ra1E,
    input  logic [`REG_ADDR_W-1:0] ra2E,
    input  logic [`REG_ADDR_W-1:0] wa3E,
    input  logic [`REG_ADDR_W-1:0] ra2M,
    input  logic [`REG_ADDR_W-1:0] wa3M,
    input  logic [`REG_ADDR_W-1:0] wa3W,
    input  logic                   regWriteE,
    input  logic                   regWriteM,
    input  logic                   regWriteW,
    input  logic                   memWriteM,
    input  logic                   memtoRegE,
    input  logic                   memtoRegW,
    input  logic                   pcSrcE,
    input  logic                   mS,
    input  logic                   mStart,
    input  pipePkg::mcycleOpT      mcycleOp,
    input  logic [`MCYCLE_W-1:0]   operand1,
    input  logic [`MCYCLE_W-1:0]   operand2,
    input  logic                   cacheHit,
    input  logic                   rw,
    input  logic                   memReadReady,
    output logic [1:0]             forwardAE,
    output logic [1:0]             forwardBE,
    output logic                   forwardM,
    output logic                   stallF,
    output logic                   stallD,
    output logic                   stallE,
    output logic                   stallM,
    output logic                   flushD,
    output logic                   flushE,
    output logic                   mcycleHazard,
    output logic                   mcycleBusy,
    output logic                   mcycleDone,
    output logic [`MCYCLE_W-1:0]   mcycleResult
);

    logic                   load;
    logic                   step;
    logic                   cntClear;
    logic                   lastStep;
    pipePkg::mcycleOpT      opLatched;
    logic [`REG_ADDR_W-1:0] mcycleWa3;

    ////////////////////////////////////////////////////////////
    // Hazard detection
    ////////////////////////////////////////////////////////////

    HazardUnit i_hazard (
        .ra1D(ra1D), .ra2D(ra2D), .wa3D(wa3D),
        .ra1E(ra1E), .ra2E(ra2E), .wa3E(wa3E),
        .ra2M(ra2M), .wa3M(wa3M), .wa3W(wa3W),
        .regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
        .memWriteM(memWriteM), .memtoRegE(memtoRegE), .memtoRegW(memtoRegW),
        .pcSrcE(pcSrcE), .mcycleWa3(mcycleWa3),
        .mcycleDone(mcycleDone), .mcycleBusy(mcycleBusy),
        .mStart(mStart), .mS(mS),
        .cacheHit(cacheHit), .rw(rw), .memReadReady(memReadReady),
        .forwardAE(forwardAE), .forwardBE(forwardBE), .forwardM(forwardM),
        .stallF(stallF), .stallD(stallD), .stallE(stallE), .stallM(stallM),
        .flushD(flushD), .flushE(flushE), .mcycleHazard(mcycleHazard)
    );

    ////////////////////////////////////////////////////////////
    // Multi-cycle unit
    ////////////////////////////////////////////////////////////

    mcycleFsm i_fsm (
        .CLK(CLK), .rstN(rstN), .mStart(mStart), .wa3E(wa3E),
        .mcycleOp(mcycleOp), .lastStep(lastStep),
        .load(load), .step(step), .cntClear(cntClear), .opLatched(opLatched),
        .mcycleBusy(mcycleBusy), .mcycleDone(mcycleDone), .mcycleWa3(mcycleWa3)
    );

    mcycleCounter i_counter (
        .CLK(CLK), .rstN(rstN), .cntClear(cntClear), .step(step),
        .lastStep(lastStep)
    );

    mcycleDatapath i_datapath (
        .CLK(CLK), .rstN(rstN), .load(load), .step(step), .opLatched(opLatched),
        .operand1(operand1), .operand2(operand2), .mcycleResult(mcycleResult)
    );

    // A multi-cycle instruction in Decode must wait while the unit is occupied
    busyBlocksNext: assert property (@(posedge CLK) disable iff (!rstN)
        (mcycleBusy && mS) |-> mcycleHazard)
        else $error("pipeCtrlTop: mS while busy without mcycleHazard");

endmodule

/* dv/tbPipeCtrlTasks.svh */
    ////////////////////////////////////////////////////////////
    // Combinational hazard tests
    ////////////////////////////////////////////////////////////

    task automatic forwardingPriority();
        begin
            @(negedge CLK);
            clearInputs();
            {ra1E, ra2E} = {4'd8, 4'd9};
            {regWriteM, regWriteW} = 2'b11;
            #2;
            if ({forwardAE, forwardBE} !== 4'b1001)
                reportMismatch("fwdSplit", 4'b1001, {forwardAE, forwardBE});
            // Same register in Memory and Writeback
            @(negedge CLK);
            {wa3M, wa3W, ra1E, ra2E} = {4{4'd5}};
            #2;
            if ({forwardAE, forwardBE} !== 4'b1010)
                reportMismatch("fwdMemWins", 4'b1010, {forwardAE, forwardBE});
            @(negedge CLK);
            regWriteM = 1'b0;
            #2;
            if ({forwardAE, forwardBE} !== 4'b0101)
                reportMismatch("fwdWbOnly", 4'b0101, {forwardAE, forwardBE});
            @(negedge CLK);
            regWriteW = 1'b0;
            #2;
            if ({forwardAE, forwardBE} !== 4'b0000)
                reportMismatch("fwdNoWrite", 4'b0000, {forwardAE, forwardBE});
            @(negedge CLK);
            clearInputs();
            {ra2M, memWriteM, memtoRegW, regWriteW} = {4'd9, 3'b111};
            #2;
            if (forwardM !== 1'b1)
                reportMismatch("fwdStore", 1'b1, forwardM);
            @(negedge CLK);
            memtoRegW = 1'b0;
            #2;
            if (forwardM !== 1'b0)
                reportMismatch("fwdStoreNoLoad", 1'b0, forwardM);
        end
    endtask

    task automatic loadUseAndBranch();
        begin
            @(negedge CLK);
            clearInputs();
            {ra1D, memtoRegE, regWriteE} = {4'd6, 2'b11};
            #2;
            if (stallFlush !== 6'b110001)
                reportMismatch("loadRa1", 6'b110001, stallFlush);
            @(negedge CLK);
            {ra1D, ra2D} = {4'd1, 4'd6};
            #2;
            if (stallFlush !== 6'b110001)
                reportMismatch("loadRa2", 6'b110001, stallFlush);
            @(negedge CLK);
            memtoRegE = 1'b0;
            #2;
            if (stallFlush !== 6'b000000)
                reportMismatch("noLoad", 6'b000000, stallFlush);
            @(negedge CLK);
            clearInputs();
            pcSrcE = 1'b1;
            #2;
            if (stallFlush !== 6'b000011)
                reportMismatch("branch", 6'b000011, stallFlush);
        end
    endtask

    task automatic memoryStall();
        begin
            @(negedge CLK);
            clearInputs();
            {cacheHit, rw, memReadReady} = 3'b000;
            #2;
            if (stallFlush !== 6'b111100)
                reportMismatch("readMiss", 6'b111100, stallFlush);
            @(negedge CLK);
            rw = 1'b1;
            #2;
            if (stallFlush !== 6'b000000)
                reportMismatch("writeMiss", 6'b000000, stallFlush);
            @(negedge CLK);
            {cacheHit, rw} = 2'b10;
            #2;
            if (stallFlush !== 6'b000000)
                reportMismatch("readHit", 6'b000000, stallFlush);
            @(negedge CLK);
            {cacheHit, memReadReady} = 2'b01;
            #2;
            if (stallFlush !== 6'b000000)
                reportMismatch("missReady", 6'b000000, stallFlush);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Multi-cycle unit tests
    ////////////////////////////////////////////////////////////

    task automatic startOperation(input mcycleOpT op, input logic [31:0] a,
                                  input logic [31:0] b);
        begin
            @(negedge CLK);
            mcycleOp = op;
            operand1 = a;
            operand2 = b;
            mStart = 1'b1;
            @(negedge CLK);
            mStart = 1'b0;
            // Operands already captured
            operand1 = ~a;
            operand2 = ~b;
        end
    endtask

    task automatic finishOperation(input string name, input logic [31:0] expected,
                                   input int elapsed);
        int   edges;
        logic busyGap;
        begin
            edges = elapsed;
            busyGap = 1'b0;
            while (!mcycleDone && edges < 40) begin
                if (!mcycleBusy)
                    busyGap = 1'b1;
                @(negedge CLK);
                edges = edges + 1;
            end
            if (busyGap)
                reportFailure($sformatf("%s: busy dropped before done", name));
            if (!mcycleDone) begin
                reportFailure($sformatf("%s: done never rose", name));
            end else begin
                if (edges != 33)
                    reportMismatch($sformatf("%s latency", name), 33, edges);
                if (mcycleBusy)
                    reportFailure($sformatf("%s: busy still high with done", name));
                if (stallD !== 1'b1)
                    reportMismatch($sformatf("%s doneStall", name), 1'b1, stallD);
                if (mcycleResult !== expected)
                    reportMismatch(name, expected, mcycleResult);
            end
            // Start during the done pulse must be dropped
            mStart = 1'b1;
            @(negedge CLK);
            mStart = 1'b0;
            if (mcycleDone || mcycleBusy)
                reportFailure($sformatf("%s: done held or start taken in done cycle", name));
            if (mcycleResult !== expected)
                reportMismatch($sformatf("%s held", name), expected, mcycleResult);
        end
    endtask

    task automatic multiplyOps();
        logic [31:0] a;
        logic [31:0] b;
        begin
            a = $random(seed);
            b = $random(seed);
            startOperation(Mul, a, b);
            finishOperation("mulRandom", a * b, 0);
            startOperation(Mul, 32'hffff_ffff, 32'd2);
            finishOperation("mulWrap", 32'hffff_fffe, 0);
            // Second start in the middle of a running multiply
            a = $random(seed);
            b = $random(seed);
            startOperation(Mul, a, b);
            repeat (5) @(negedge CLK);
            mStart = 1'b1;
            @(negedge CLK);
            mStart = 1'b0;
            finishOperation("mulRestart", a * b, 6);
        end
    endtask

    task automatic divideOps();
        logic [31:0] a;
        logic [31:0] b;
        begin
            // First divide right after a multiply, with distinct operands
            a = $random(seed);
            b = ($random(seed) >> 20) | 32'd1;
            startOperation(Divu, a, b);
            finishOperation("divSmall", a / b, 0);
            a = $random(seed) | 32'd1;
            startOperation(Divu, a, a);
            finishOperation("divSelf", 32'd1, 0);
            a = $random(seed);
            b = $random(seed) | 32'd1;
            startOperation(Divu, a, b);
            finishOperation("divWide", a / b, 0);
            a = $random(seed);
            startOperation(Divu, a, 32'd0);
            finishOperation("divZero", 32'hffff_ffff, 0);
        end
    endtask

    task automatic multicycleHazard();
        logic [31:0] a;
        logic [31:0] b;
        begin
            a = $random(seed);
            b = $random(seed);
            clearInputs();
            wa3E = 4'd10;
            startOperation(Mul, a, b);
            // r10 now belongs to the unit
            wa3E = 4'd6;
            ra1D = 4'd10;
            #2;
            if ({stallD, mcycleHazard} !== 2'b11)
                reportMismatch("hazReadBusy", 2'b11, {stallD, mcycleHazard});
            @(negedge CLK);
            ra1D = 4'd1;
            #2;
            if ({stallD, mcycleHazard} !== 2'b00)
                reportMismatch("hazClear", 2'b00, {stallD, mcycleHazard});
            @(negedge CLK);
            mS = 1'b1;
            #2;
            if ({stallD, mcycleHazard} !== 2'b01)
                reportMismatch("hazMcycleInDecode", 2'b01, {stallD, mcycleHazard});
            @(negedge CLK);
            {mS, wa3D} = {1'b0, 4'd10};
            #2;
            if ({stallD, mcycleHazard} !== 2'b11)
                reportMismatch("hazWriteBusy", 2'b11, {stallD, mcycleHazard});
            @(negedge CLK);
            wa3D = 4'd3;
            finishOperation("hazMul", a * b, 4);
            // Idle unit, conflict flagged but no stall
            @(negedge CLK);
            ra2D = 4'd10;
            #2;
            if ({stallD, mcycleHazard} !== 2'b01)
                reportMismatch("hazIdle", 2'b01, {stallD, mcycleHazard});
        end
    endtask

/* dv/tbPipeCtrl.sv */
`timescale 1ns/1ns

`include "pipe_defines.svh"

module tbPipeCtrl;

    import pipePkg::*;

    // Eight operations of about 36 cycles plus the combinational checks, with margin
    localparam int cycleLimit = 600;

    logic                   CLK = 1'b0;
    logic                   rstN;
    logic [`REG_ADDR_W-1:0] ra1D, ra2D, wa3D;
    logic [`REG_ADDR_W-1:0] ra1E, ra2E, wa3E;
    logic [`REG_ADDR_W-1:0] ra2M, wa3M, wa3W;
    logic                   regWriteE, regWriteM, regWriteW;
    logic                   memWriteM, memtoRegE, memtoRegW, pcSrcE;
    logic                   mS, mStart;
    mcycleOpT               mcycleOp;
    logic [`MCYCLE_W-1:0]   operand1, operand2;
    logic                   cacheHit, rw, memReadReady;
    logic [1:0]             forwardAE, forwardBE;
    logic                   forwardM;
    logic                   stallF, stallD, stallE, stallM;
    logic                   flushD, flushE;
    logic                   mcycleHazard, mcycleBusy, mcycleDone;
    logic [`MCYCLE_W-1:0]   mcycleResult;

    // Bit order F D E M, then flushD flushE
    logic [5:0]             stallFlush;

    integer                 seed;
    int                     mismatchCount;
    int                     failCount;
    int                     cycleCount = 0;

    assign stallFlush = {stallF, stallD, stallE, stallM, flushD, flushE};

    pipeCtrlTop i_dut (.*);

    always #4 CLK = ~CLK;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic clearInputs();
        begin
            // Distinct registers so nothing matches by default
            {ra1D, ra2D, wa3D} = {4'd1, 4'd2, 4'd3};
            {ra1E, ra2E, wa3E} = {4'd4, 4'd5, 4'd6};
            {ra2M, wa3M, wa3W} = {4'd7, 4'd8, 4'd9};
            {regWriteE, regWriteM, regWriteW} = 3'b000;
            {memWriteM, memtoRegE, memtoRegW, pcSrcE} = 4'b0000;
            {mS, mStart} = 2'b00;
            mcycleOp = Mul;
            operand1 = '0;
            operand2 = '0;
            // Read hit
            {cacheHit, rw, memReadReady} = 3'b100;
        end
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        begin
            $display("mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            mismatchCount = mismatchCount + 1;
        end
    endtask

    task automatic reportFailure(input string msg);
        begin
            $display("Error: %s", msg);
            failCount = failCount + 1;
        end
    endtask

    `include "tbPipeCtrlTasks.svh"

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        seed = 32'h2ef4_9550;
        mismatchCount = 0;
        failCount = 0;
        clearInputs();
        rstN = 1'b0;
        repeat (8) @(negedge CLK);
        rstN = 1'b1;

        forwardingPriority();
        loadUseAndBranch();
        memoryStall();
        multiplyOps();
        divideOps();
        multicycleHazard();

        $display("Checks done: %0d mismatches, %0d other errors", mismatchCount, failCount);
        if (mismatchCount + failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Checks done: %0d mismatches, %0d other errors", mismatchCount, failCount);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

/* pipeCtrl.f */
+incdir+source
+incdir+dv
source/pipePkg.sv
source/HazardUnit.sv
source/mcycleFsm.sv
source/mcycleCounter.sv
source/mcycleDatapath.sv
source/pipeCtrlTop.sv
dv/tbPipeCtrl.sv

/* Bender.yml */
package:
  name: pipeCtrl

sources:
  - include_dirs:
      - source
    files:
      - source/pipePkg.sv
      - source/HazardUnit.sv
      - source/mcycleFsm.sv
      - source/mcycleCounter.sv
      - source/mcycleDatapath.sv
      - source/pipeCtrlTop.sv
  - target: test
    include_dirs:
      - source
      - dv
    files:
      - dv/tbPipeCtrl.sv
